/* include/fft_defines.svh */
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// Q4.4 signed samples
`define FFT_INT_BITS 4
`define FFT_FRAC_BITS 4
`define FFT_SAMPLE_W (`FFT_INT_BITS + `FFT_FRAC_BITS)

// Transform size and number of radix-2 stages
`define FFT_POINTS 8
`define FFT_STAGES 3

`endif

/* src/fft_pkg.sv */
`include "fft_defines.svh"

package fft_pkg;

  // One signed fixed-point component
  typedef logic signed [`FFT_SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  // Whole frame or spectrum, element 0 in the low bits
  typedef cplx_t [`FFT_POINTS-1:0] frame_t;

  typedef logic [`FFT_STAGES-1:0] point_idx_t;

  function automatic point_idx_t bit_reverse(input point_idx_t idx);
    point_idx_t rev;
    rev = '0;
    for (int i = 0; i < `FFT_STAGES; i++) begin
      rev[i] = idx[`FFT_STAGES-1-i];
    end
    return rev;
  endfunction

  // W^k = exp(-j*2*pi*k/8), scaled by 16
  function automatic cplx_t twiddle(input logic [1:0] k);
    cplx_t w;
    case (k)
      2'd0: begin
        w.re = sample_t'(16);
        w.im = sample_t'(0);
      end
      2'd1: begin
        w.re = sample_t'(11);
        w.im = sample_t'(-11);
      end
      2'd2: begin
        w.re = sample_t'(0);
        w.im = sample_t'(-16);
      end
      default: begin
        w.re = sample_t'(-11);
        w.im = sample_t'(-11);
      end
    endcase
    return w;
  endfunction

endpackage

/* src/fft_pipe_reg.sv */
`timescale 1ns/1ps

module fft_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Free when empty or when the held beat leaves this cycle
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule

/* src/fft_butterfly_stage.sv */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_butterfly_stage #(
  parameter int STAGE = 0
) (
  input  fft_pkg::frame_t frame_i,
  output fft_pkg::frame_t frame_o
);
  import fft_pkg::*;

  localparam int SPAN    = 1 << STAGE;
  localparam int TW_STEP = (`FFT_POINTS / 2) / SPAN;
  localparam int PROD_W  = 2 * `FFT_SAMPLE_W;

  // Full-width product, keep bits 3 down to -4 (wraps on overflow)
  function automatic cplx_t cplx_mul(input cplx_t x, input cplx_t w);
    logic signed [PROD_W-1:0] prod_re;
    logic signed [PROD_W-1:0] prod_im;
    cplx_t                    y;
    prod_re = x.re * w.re - x.im * w.im;
    prod_im = x.im * w.re + x.re * w.im;
    y.re    = prod_re[PROD_W-`FFT_INT_BITS-1:`FFT_FRAC_BITS];
    y.im    = prod_im[PROD_W-`FFT_INT_BITS-1:`FFT_FRAC_BITS];
    return y;
  endfunction

  for (genvar g = 0; g < `FFT_POINTS; g += 2 * SPAN) begin : g_group
    for (genvar j = 0; j < SPAN; j++) begin : g_fly
      localparam int LO   = g + j;
      localparam int HI   = LO + SPAN;
      localparam int TW_K = j * TW_STEP;

      cplx_t prod;

      assign prod = cplx_mul(frame_i[HI], twiddle(2'(TW_K)));

      // Sum to the lower slot, difference to the upper, 8-bit wrap
      assign frame_o[LO] = '{
        re: sample_t'(frame_i[LO].re + prod.re),
        im: sample_t'(frame_i[LO].im + prod.im)
      };
      assign frame_o[HI] = '{
        re: sample_t'(frame_i[LO].re - prod.re),
        im: sample_t'(frame_i[LO].im - prod.im)
      };
    end
  end

endmodule

/* src/fft_sample_loader.sv */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_sample_loader (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  fft_pkg::cplx_t  in_sample_i,
  output logic            frame_valid_o,
  input  logic            frame_ready_i,
  output fft_pkg::frame_t frame_o
);
  import fft_pkg::*;

  point_idx_t wr_count;
  frame_t     frame_q;
  logic       full_q;
  logic       sample_fire;
  logic       frame_fire;

  assign sample_fire   = in_valid_i && in_ready_o;
  assign frame_fire    = frame_valid_o && frame_ready_i;

  // Input stalls while a complete frame waits downstream
  assign in_ready_o    = !full_q;
  assign frame_valid_o = full_q;
  assign frame_o       = frame_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_count <= '0;
      full_q   <= 1'b0;
    end else begin
      if (sample_fire) begin
        // Count wraps to 0 on the last sample
        wr_count <= wr_count + 1'b1;
        if (wr_count == point_idx_t'(`FFT_POINTS - 1)) begin
          full_q <= 1'b1;
        end
      end
      if (frame_fire) begin
        full_q <= 1'b0;
      end
    end
  end

  // DIT ordering: sample n lands in slot bitrev(n)
  always_ff @(posedge clk) begin
    if (sample_fire) begin
      frame_q[bit_reverse(wr_count)] <= in_sample_i;
    end
  end

endmodule

/* src/fft_bin_serializer.sv */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_bin_serializer (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            frame_valid_i,
  output logic            frame_ready_o,
  input  fft_pkg::frame_t frame_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output fft_pkg::cplx_t  out_bin_o,
  output logic            out_last_o
);
  import fft_pkg::*;

  frame_t     spec_q;
  point_idx_t bin_q;
  logic       busy_q;

  assign frame_ready_o = !busy_q;
  assign out_valid_o   = busy_q;
  assign out_bin_o     = spec_q[bin_q];
  assign out_last_o    = (bin_q == point_idx_t'(`FFT_POINTS - 1));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      bin_q  <= '0;
    end else if (frame_valid_i && frame_ready_o) begin
      busy_q <= 1'b1;
      bin_q  <= '0;
    end else if (out_valid_o && out_ready_i) begin
      // Counter wraps back to bin 0 after the last one
      bin_q <= bin_q + 1'b1;
      if (out_last_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_valid_i && frame_ready_o) begin
      spec_q <= frame_i;
    end
  end

endmodule

/* src/fft_top.sv */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_top (
  input  logic           clk,
  input  logic           reset_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,
  input  fft_pkg::cplx_t in_sample_i,
  output logic           out_valid_o,
  input  logic           out_ready_i,
  output fft_pkg::cplx_t out_bin_o,
  output logic           out_last_o
);
  import fft_pkg::*;

  // Handshake k feeds register k; handshake 4 feeds the serializer
  logic [`FFT_STAGES+1:0] pipe_valid;
  logic [`FFT_STAGES+1:0] pipe_ready;

  // Register inputs (loader, then stage outputs) and register outputs
  frame_t reg_d [`FFT_STAGES+1];
  frame_t reg_q [`FFT_STAGES+1];

  fft_sample_loader u_loader (
    .clk           (clk),
    .reset_i       (reset_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_sample_i   (in_sample_i),
    .frame_valid_o (pipe_valid[0]),
    .frame_ready_i (pipe_ready[0]),
    .frame_o       (reg_d[0])
  );

  for (genvar k = 0; k <= `FFT_STAGES; k++) begin : g_reg
    fft_pipe_reg #(
      .payload_t (frame_t)
    ) u_reg (
      .clk     (clk),
      .reset_i (reset_i),
      .valid_i (pipe_valid[k]),
      .ready_o (pipe_ready[k]),
      .data_i  (reg_d[k]),
      .valid_o (pipe_valid[k+1]),
      .ready_i (pipe_ready[k+1]),
      .data_o  (reg_q[k])
    );
  end

  // Stage k sits between register k and register k+1
  for (genvar k = 0; k < `FFT_STAGES; k++) begin : g_stage
    fft_butterfly_stage #(
      .STAGE (k)
    ) u_stage (
      .frame_i (reg_q[k]),
      .frame_o (reg_d[k+1])
    );
  end

  fft_bin_serializer u_serializer (
    .clk           (clk),
    .reset_i       (reset_i),
    .frame_valid_i (pipe_valid[`FFT_STAGES+1]),
    .frame_ready_o (pipe_ready[`FFT_STAGES+1]),
    .frame_i       (reg_q[`FFT_STAGES]),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_bin_o     (out_bin_o),
    .out_last_o    (out_last_o)
  );

endmodule

/* dv/fft_properties.sv */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_properties (
  input logic           clk,
  input logic           reset_i,
  input logic           in_valid_i,
  input logic           in_ready_o,
  input fft_pkg::cplx_t in_sample_i,
  input logic           out_valid_o,
  input logic           out_ready_i,
  input fft_pkg::cplx_t out_bin_o,
  input logic           out_last_o
);
  import fft_pkg::*;

  // W^k scaled by 16, k = 0..3
  localparam int W_RE [4] = '{16, 11, 0, -11};
  localparam int W_IM [4] = '{0, -11, -16, -11};

  int         fail_count = 0;
  frame_t     in_frame;
  logic [2:0] in_count;
  cplx_t      exp_mem [128];
  logic [6:0] wr_ptr;
  logic [6:0] rd_ptr;
  logic [6:0] queued;
  logic [2:0] out_count;
  cplx_t      exp_bin;

  assign queued  = wr_ptr - rd_ptr;
  assign exp_bin = exp_mem[rd_ptr];

  function automatic int wrap8(input int v);
    logic signed [7:0] t;
    t = v[7:0];
    return int'(t);
  endfunction

  // Radix-2 DIT reference with Q4.4 truncation and 8-bit wrap
  function automatic frame_t model_fft(input frame_t x);
    int     re [8];
    int     im [8];
    int     span;
    int     lo;
    int     hi;
    int     k;
    int     pr;
    int     pi;
    int     t_re;
    int     t_im;
    frame_t y;
    for (int n = 0; n < 8; n++) begin
      re[{n[0], n[1], n[2]}] = int'(x[n].re);
      im[{n[0], n[1], n[2]}] = int'(x[n].im);
    end
    for (int s = 0; s < 3; s++) begin
      span = 1 << s;
      for (int g = 0; g < 8; g += 2 * span) begin
        for (int j = 0; j < span; j++) begin
          lo   = g + j;
          hi   = lo + span;
          k    = j * (4 / span);
          pr   = wrap8((re[hi] * W_RE[k] - im[hi] * W_IM[k]) >>> 4);
          pi   = wrap8((im[hi] * W_RE[k] + re[hi] * W_IM[k]) >>> 4);
          t_re = re[lo];
          t_im = im[lo];
          re[lo] = wrap8(t_re + pr);
          im[lo] = wrap8(t_im + pi);
          re[hi] = wrap8(t_re - pr);
          im[hi] = wrap8(t_im - pi);
        end
      end
    end
    for (int n = 0; n < 8; n++) begin
      y[n].re = sample_t'(re[n]);
      y[n].im = sample_t'(im[n]);
    end
    return y;
  endfunction

  // Capture input frames and queue the expected bins
  always_ff @(posedge clk) begin
    frame_t spectrum;
    if (reset_i) begin
      in_count  <= 3'd0;
      wr_ptr    <= 7'd0;
      rd_ptr    <= 7'd0;
      out_count <= 3'd0;
    end else begin
      if (in_valid_i && in_ready_o) begin
        in_frame[in_count] <= in_sample_i;
        in_count <= in_count + 3'd1;
        if (in_count == 3'd7) begin
          spectrum    = in_frame;
          spectrum[7] = in_sample_i;
          spectrum    = model_fft(spectrum);
          for (int i = 0; i < 8; i++) begin
            exp_mem[wr_ptr + 7'(i)] <= spectrum[i];
          end
          wr_ptr <= wr_ptr + 7'd8;
        end
      end
      if (out_valid_o && out_ready_i) begin
        rd_ptr    <= rd_ptr + 7'd1;
        out_count <= out_count + 3'd1;
      end
    end
  end

  reset_state: assert property (@(posedge clk) reset_i |=> !out_valid_o && in_ready_o)
    else begin
      fail_count++;
      $error("outputs not idle after reset");
    end

  no_extra_bin: assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o |-> queued != 7'd0)
    else begin
      fail_count++;
      $error("output bin presented with no frame sent in");
    end

  bin_matches: assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o && queued != 7'd0 |-> out_bin_o == exp_bin)
    else begin
      fail_count++;
      $error("FAILED out_bin_o expected %h actual %h", $sampled(exp_bin), $sampled(out_bin_o));
    end

  last_on_eighth: assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o |-> out_last_o == (out_count == 3'd7))
    else begin
      fail_count++;
      $error("FAILED out_last_o expected %h actual %h",
             $sampled(out_count == 3'd7), $sampled(out_last_o));
    end

  stall_stable: assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(out_bin_o) && $stable(out_last_o))
    else begin
      fail_count++;
      $error("output bin changed or vanished while stalled");
    end

endmodule

bind fft_top fft_properties props_i (
  .clk         (clk),
  .reset_i     (reset_i),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .in_sample_i (in_sample_i),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_bin_o   (out_bin_o),
  .out_last_o  (out_last_o)
);

/* dv/fft_tb.sv */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_tb;
  import fft_pkg::*;

  localparam int WAIT_LIMIT = 2000;

  logic   clk;
  logic   reset_i;
  logic   in_valid_i;
  logic   in_ready_o;
  cplx_t  in_sample_i;
  logic   out_valid_o;
  logic   out_ready_i = 1'b1;
  cplx_t  out_bin_o;
  logic   out_last_o;

  int     seed;
  int     beats_seen = 0;
  int     stall_left = 0;
  int     tests_run;
  int     tests_failed;
  int     fails_before;
  logic   timed_out;
  logic   backpressure_on = 1'b0;
  frame_t frames [8];

  fft_top dut_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_sample_i (in_sample_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_bin_o   (out_bin_o),
    .out_last_o  (out_last_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Random stall spans on the output side
  always @(posedge clk) begin
    if (stall_left > 0) begin
      out_ready_i <= 1'b0;
      stall_left  <= stall_left - 1;
    end else if (backpressure_on && ($random(seed) % 2 == 0)) begin
      out_ready_i <= 1'b0;
      stall_left  <= {$random(seed)} % 8;
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (out_valid_o && out_ready_i) begin
      beats_seen <= beats_seen + 1;
    end
  end

  task automatic send_sample(input cplx_t s);
    int waited;
    waited = 0;
    in_valid_i  <= 1'b1;
    in_sample_i <= s;
    @(posedge clk);
    while (!in_ready_o && !timed_out) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: DUT stopped accepting input samples");
        timed_out = 1'b1;
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_for_beats(input int target);
    int waited;
    waited = 0;
    while (beats_seen < target && !timed_out) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: output bins stopped before all frames came out");
        timed_out = 1'b1;
      end
      @(posedge clk);
    end
  endtask

  task automatic run_frames(input int count);
    int target;
    target = beats_seen + `FFT_POINTS * count;
    for (int f = 0; f < count; f++) begin
      for (int n = 0; n < `FFT_POINTS; n++) begin
        send_sample(frames[f][n]);
      end
    end
    in_valid_i <= 1'b0;
    wait_for_beats(target);
  endtask

  task automatic fill_random(input int count);
    for (int f = 0; f < count; f++) begin
      for (int n = 0; n < `FFT_POINTS; n++) begin
        frames[f][n].re = sample_t'($random(seed));
        frames[f][n].im = sample_t'($random(seed));
      end
    end
  endtask

  task automatic finish_test(input string name);
    int fails;
    fails = dut_i.props_i.fail_count - fails_before;
    fails_before = dut_i.props_i.fail_count;
    tests_run++;
    if (fails != 0 || timed_out) begin
      tests_failed++;
      $display("test %0s: %0d assertion failure(s), timeout %0d", name, fails, timed_out);
    end else begin
      $display("test %0s: ok", name);
    end
  endtask

  initial begin
    seed         = 32'h293a;
    tests_run    = 0;
    tests_failed = 0;
    fails_before = 0;
    timed_out    = 1'b0;
    reset_i      = 1'b1;
    in_valid_i   = 1'b0;
    in_sample_i  = '0;
    repeat (16) @(posedge clk);
    reset_i <= 1'b0;
    repeat (2) @(posedge clk);
    finish_test("reset");

    frames[0]       = '0;
    frames[0][0].re = sample_t'(16);
    run_frames(1);
    finish_test("impulse");

    for (int n = 0; n < `FFT_POINTS; n++) begin
      frames[0][n].re = sample_t'(3);
      frames[0][n].im = sample_t'(0);
    end
    run_frames(1);
    finish_test("constant");

    fill_random(4);
    run_frames(4);
    finish_test("random frames");

    // Stalls start at the next edge
    fill_random(8);
    backpressure_on <= 1'b1;
    run_frames(8);
    backpressure_on <= 1'b0;
    finish_test("back-pressure");

    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             tests_run, tests_failed, dut_i.props_i.fail_count);
    if (tests_failed == 0 && dut_i.props_i.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
src/fft_pkg.sv
src/fft_pipe_reg.sv
src/fft_butterfly_stage.sv
src/fft_sample_loader.sv
src/fft_bin_serializer.sv
src/fft_top.sv
dv/fft_properties.sv
dv/fft_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the FFT testbench with Verilator, runs it, and checks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module fft_tb || exit 1
out=$(./obj_dir/Vfft_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1
